// File: vlog.f
+incdir+hw
hw/packer_pkg.sv
hw/ring_fifo.sv
hw/byte_packer.sv
hw/frame_packer_top.sv
tests/frame_packer_sva.sv
tests/frame_packer_tb.sv

// File: tests/frame_packer_tb.sv
// Testbench for the frame packer with stimulus, reference model, compare tasks and timeout

`include "packer_config.svh"

module frame_packer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic reset_n;
  packer_pkg::byte_t  i_data;
  logic i_last, i_data_val, o_ready;
  packer_pkg::word_t  o_word;
  packer_pkg::count_t o_count;
  logic o_last, o_word_val, i_word_en, o_word_near_empty;

  // Accepted bytes and their last flags in the order the DUT took them
  packer_pkg::byte_t exp_bytes[$];
  logic              exp_lasts[$];
  int frame_len[$];
  int words_expected = 0;
  int words_seen     = 0;
  int cycle_count    = 0;
  int cycle_limit    = 0;
  // Consumer enable mode is 0 for always on, 1 for held low and 2 for random
  int en_mode        = 0;

  frame_packer_top i_dut (.*);

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    stop_with_failure($sformatf("** Error at %0t ns: %s", $time, msg));
  endtask

  // Assertion failures counted by the bound checkers
  function automatic int assertion_failures();
    return i_dut.u_in_fifo.u_sva.error_count + i_dut.u_out_fifo.u_sva.error_count
         + i_dut.u_packer.u_sva.error_count;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic compare_word(input packer_pkg::word_t got, input packer_pkg::word_t exp);
    if (got !== exp) report_error($sformatf("o_word expected %h got %h", exp, got));
  endtask

  task automatic compare_count(input packer_pkg::count_t got, input packer_pkg::count_t exp);
    if (got !== exp) report_error($sformatf("o_count expected %0d got %0d", exp, got));
  endtask

  task automatic compare_last(input logic got, input logic exp);
    if (got !== exp) report_error($sformatf("o_last expected %b got %b", exp, got));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_error($sformatf("%s expected %b got %b", name, exp, got));
  endtask

  // Takes the next word of the frame with the first byte in lane 0
  // The word closes at four bytes or at the byte that carries last
  function automatic void expected_word(output packer_pkg::word_t w,
                                        output packer_pkg::count_t c, output logic l);
    int n;
    w = '0;
    l = 1'b0;
    n = 0;
    while (n < `PACK_BYTES_PER_WORD && !l && exp_bytes.size() > 0) begin
      w[n*8 +: 8] = exp_bytes.pop_front();
      l = exp_lasts.pop_front();
      n++;
    end
    c = packer_pkg::count_t'(n - 1);
  endfunction

  // Sends one frame, optionally with idle cycles, and waits for each byte to be taken
  task automatic send_frame(input int len, input bit gaps);
    packer_pkg::byte_t b;
    logic accepted;
    for (int i = 0; i < len; i++) begin
      while (gaps && $urandom_range(3, 0) == 0) begin
        i_data_val = 1'b0;
        @(posedge clk);
        #10;
      end
      b = packer_pkg::byte_t'($urandom);
      i_data = b;
      i_last = (i == len - 1);
      i_data_val = 1'b1;
      do begin
        @(negedge clk);
        accepted = o_ready;
        @(posedge clk);
        #10;
      end while (!accepted);
      exp_bytes.push_back(b);
      exp_lasts.push_back(i == len - 1);
    end
    i_data_val = 1'b0;
  endtask

  // Consumer enable follows the current mode and is driven just after each edge
  always @(posedge clk) begin
    #10;
    case (en_mode)
      0: i_word_en = 1'b1;
      1: i_word_en = 1'b0;
      default: i_word_en = ($urandom_range(3, 0) != 0);
    endcase
  end

  // Checks every word the consumer pops against the reference model
  always @(negedge clk) begin : compare
    packer_pkg::word_t  w;
    packer_pkg::count_t c;
    logic l;
    // An empty egress FIFO cannot hold exactly one word
    if (reset_n && !o_word_val) begin
      compare_flag("o_word_near_empty", o_word_near_empty, 1'b0);
    end
    if (reset_n && o_word_val && i_word_en) begin
      if (exp_bytes.size() == 0) stop_with_failure("A word came out with no byte left to match");
      expected_word(w, c, l);
      compare_word(o_word, w);
      compare_count(o_count, c);
      compare_last(o_last, l);
      // No accepted byte is left behind this word, so it is the only one stored
      if (exp_bytes.size() == 0) begin
        compare_flag("o_word_near_empty", o_word_near_empty, 1'b1);
      end
      words_seen++;
    end
  end

  always @(negedge clk) begin
    if (assertion_failures() != 0) begin
      stop_with_failure("A bound assertion failed during the run");
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      stop_with_failure($sformatf("Run timed out after %0d cycles, %0d of %0d words seen",
                                  cycle_count, words_seen, words_expected));
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin : stimulus
    int sva_errors;
    void'($urandom(16));
    reset_n = 1'b0;
    i_data = '0;
    i_last = 1'b0;
    i_data_val = 1'b0;
    i_word_en = 1'b0;
    // Short frames and a nine byte frame come first
    // One long frame under back-pressure follows, then the random frames
    frame_len = '{1, 2, 3, 9, 40};
    repeat (200) frame_len.push_back($urandom_range(12, 1));
    foreach (frame_len[i]) words_expected += (frame_len[i] + 3) / 4;
    cycle_limit = 20 * frame_len.sum() + 200;
    repeat (5) @(posedge clk);
    #10;
    reset_n = 1'b1;
    @(negedge clk);
    compare_flag("o_ready", o_ready, 1'b1);
    compare_flag("o_word_val", o_word_val, 1'b0);
    compare_flag("o_word_near_empty", o_word_near_empty, 1'b0);
    @(posedge clk);
    #10;
    for (int i = 0; i < 4; i++) send_frame(frame_len[i], 1'b0);
    // Hold the consumer off until the ingress side stalls, then let it drain
    en_mode = 1;
    fork
      send_frame(frame_len[4], 1'b0);
      begin
        do @(negedge clk); while (o_ready);
        repeat (5) @(posedge clk);
        en_mode = 0;
      end
    join
    en_mode = 2;
    for (int i = 5; i < frame_len.size(); i++) send_frame(frame_len[i], 1'b1);
    en_mode = 0;
    while (words_seen < words_expected) @(negedge clk);
    repeat (10) @(posedge clk);
    @(negedge clk);
    sva_errors = assertion_failures();
    if (exp_bytes.size() != 0 || o_word_val || sva_errors != 0) begin
      stop_with_failure($sformatf("Run ended with %0d bytes unmatched, extra word %b, %0d %s",
                                  exp_bytes.size(), o_word_val, sva_errors,
                                  "assertion failures"));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: tests/frame_packer_sva.sv
// Bound assertions on FIFO status flags and the valid and enable handshake of each stage

module frame_packer_sva #(
  parameter int WIDTH     = 8,
  parameter bit HAS_FLAGS = 1'b1
) (
  input logic             clk,
  input logic             reset_n,
  input logic             i_full,
  input logic             i_empty,
  input logic             i_near_empty,
  input logic             i_val,
  input logic             i_en,
  input logic [WIDTH-1:0] i_entry
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures in this instance
  int error_count = 0;

  // An offered entry stays put until the receiving side takes it
  hold_until_taken: assert property (@(posedge clk) disable iff (!reset_n)
    i_val && !i_en |=> i_val && $stable(i_entry))
    else begin
      error_count++;
      $error("valid dropped or entry changed before it was taken");
    end

  // ------------------------------
  // FIFO flags
  // ------------------------------

  if (HAS_FLAGS) begin : g_flags
    full_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
      !(i_full && i_empty))
      else begin
        error_count++;
        $error("full and empty are both high");
      end

    // One stored entry is never an empty FIFO
    near_empty_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
      i_near_empty |-> !i_empty)
      else begin
        error_count++;
        $error("nearly-empty is high while empty");
      end

    // Popping one of two or more stored entries leaves a valid head behind
    pop_keeps_valid: assert property (@(posedge clk) disable iff (!reset_n)
      i_val && i_en && !i_near_empty |=> i_val)
      else begin
        error_count++;
        $error("head valid dropped after a pop that left entries stored");
      end
  end

endmodule

// Every FIFO gets the flag checks and the packer only the handshake check
bind ring_fifo frame_packer_sva #(.WIDTH(WIDTH), .HAS_FLAGS(1'b1)) u_sva (
  .clk(clk), .reset_n(reset_n), .i_full(o_full), .i_empty(o_empty),
  .i_near_empty(o_near_empty), .i_val(o_data_val), .i_en(i_en), .i_entry(o_data)
);

bind byte_packer frame_packer_sva #(
  .WIDTH($bits(packer_pkg::out_entry_t)), .HAS_FLAGS(1'b0)
) u_sva (
  .clk(clk), .reset_n(reset_n), .i_full(1'b0), .i_empty(1'b0), .i_near_empty(1'b0),
  .i_val(o_word_val), .i_en(i_word_en), .i_entry(o_word_entry)
);

// File: hw/frame_packer_top.sv
// Top level of the frame byte packer with ingress FIFO, packer and egress FIFO

`include "packer_config.svh"

module frame_packer_top (
  input  logic               clk,
  input  logic               reset_n,

  // Byte stream from the producer
  input  packer_pkg::byte_t  i_data,
  input  logic               i_last,
  input  logic               i_data_val,
  output logic               o_ready,

  // Packed words towards the consumer
  output packer_pkg::word_t  o_word,
  output packer_pkg::count_t o_count,
  output logic               o_last,
  output logic               o_word_val,
  input  logic               i_word_en,
  output logic               o_word_near_empty
);

  localparam int IN_W  = $bits(packer_pkg::in_entry_t);
  localparam int OUT_W = $bits(packer_pkg::out_entry_t);
  localparam int WORD_W = $bits(packer_pkg::word_t);

  // ------------------------------
  // Ingress FIFO to packer
  // ------------------------------

  packer_pkg::in_entry_t  in_head;
  logic                   in_head_val;
  logic                   in_pop;

  // ------------------------------
  // Packer to egress FIFO
  // ------------------------------

  packer_pkg::out_entry_t pack_entry;
  logic                   pack_val;
  logic                   out_en;
  packer_pkg::out_entry_t out_head;

  // Ingress takes the byte with its last flag on top
  // Its full, empty and nearly-empty flags are not needed here
  ring_fifo #(
    .WIDTH (IN_W),
    .DEPTH (`PACK_IN_DEPTH)
  ) u_in_fifo (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_data       ({i_last, i_data}),
    .i_data_val   (i_data_val),
    .o_en         (o_ready),
    .i_en         (in_pop),
    .o_data       (in_head),
    .o_data_val   (in_head_val),
    .o_full       (),
    .o_empty      (),
    .o_near_empty ()
  );

  byte_packer u_packer (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_entry      (in_head),
    .i_entry_val  (in_head_val),
    .o_entry_en   (in_pop),
    .o_word_entry (pack_entry),
    .o_word_val   (pack_val),
    .i_word_en    (out_en)
  );

  // A full egress FIFO holds the packer in EMIT, which backs up the ingress side
  ring_fifo #(
    .WIDTH (OUT_W),
    .DEPTH (`PACK_OUT_DEPTH)
  ) u_out_fifo (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_data       (pack_entry),
    .i_data_val   (pack_val),
    .o_en         (out_en),
    .i_en         (i_word_en),
    .o_data       (out_head),
    .o_data_val   (o_word_val),
    .o_full       (),
    .o_empty      (),
    .o_near_empty (o_word_near_empty)
  );

  // Egress head split into last flag, count and word
  assign o_word  = out_head[WORD_W-1:0];
  assign o_count = out_head[OUT_W-2:WORD_W];
  assign o_last  = out_head[OUT_W-1];

endmodule

// File: hw/byte_packer.sv
// Packer FSM that gathers frame bytes into words and hands each word to the egress FIFO

`include "packer_config.svh"

module byte_packer (
  input  logic                   clk,
  input  logic                   reset_n,

  // Head of the ingress FIFO and its pop enable
  input  packer_pkg::in_entry_t  i_entry,
  input  logic                   i_entry_val,
  output logic                   o_entry_en,

  // Finished word towards the egress FIFO write side
  output packer_pkg::out_entry_t o_word_entry,
  output logic                   o_word_val,
  input  logic                   i_word_en
);

  localparam int BYTE_W = $bits(packer_pkg::byte_t);
  localparam int LANES  = `PACK_BYTES_PER_WORD;

  packer_pkg::pack_state_e state;

  // Bytes gathered so far for the word under construction
  packer_pkg::word_t       word_q;

  // Lane the next popped byte goes into
  packer_pkg::count_t      lane_q;

  // Word as it leaves the packer, with the final byte merged in
  packer_pkg::word_t       word_fill;

  packer_pkg::byte_t       in_byte;
  logic                    in_last;
  logic                    pop;
  logic                    word_done;

  // ------------------------------
  // Entry fields and handshake
  // ------------------------------

  // Last flag sits right above the byte in the ingress entry
  assign in_byte = i_entry[BYTE_W-1:0];
  assign in_last = i_entry[BYTE_W];

  // Pops are only requested while collecting, EMIT never takes a byte
  assign o_entry_en = (state == packer_pkg::COLLECT);
  assign o_word_val = (state == packer_pkg::EMIT);

  assign pop = o_entry_en & i_entry_val;

  // The word closes on its top lane or at the end of the frame
  assign word_done = in_last | (lane_q == packer_pkg::count_t'(LANES - 1));

  // Merge the closing byte, lanes above it are forced to zero
  always_comb begin
    word_fill = '0;
    for (int l = 0; l < LANES; l++) begin
      if (l < lane_q) begin
        word_fill[l*BYTE_W +: BYTE_W] = word_q[l*BYTE_W +: BYTE_W];
      end else if (l == lane_q) begin
        word_fill[l*BYTE_W +: BYTE_W] = in_byte;
      end
    end
  end

  // ------------------------------
  // FSM and lane index
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state  <= packer_pkg::COLLECT;
      lane_q <= '0;
    end else begin
      case (state)
        packer_pkg::COLLECT: begin
          if (pop) begin
            if (word_done) begin
              // Lane index is kept so the count stays visible until the word leaves
              state <= packer_pkg::EMIT;
            end else begin
              lane_q <= lane_q + 1'b1;
            end
          end
        end
        packer_pkg::EMIT: begin
          // Egress took the word this cycle, start the next one from lane 0
          if (i_word_en) begin
            state  <= packer_pkg::COLLECT;
            lane_q <= '0;
          end
        end
        default: begin
          state <= packer_pkg::COLLECT;
        end
      endcase
    end
  end

  // ------------------------------
  // Word datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (pop) begin
      if (word_done) begin
        // Count is the lane of the closing byte, last comes from that byte
        o_word_entry <= {in_last, lane_q, word_fill};
      end else begin
        word_q[lane_q*BYTE_W +: BYTE_W] <= in_byte;
      end
    end
    // Wipe the gathered bytes once the word has gone to the egress FIFO
    if (o_word_val && i_word_en) begin
      word_q <= '0;
    end
  end

endmodule

// File: hw/ring_fifo.sv
// Synchronous FIFO with rotating one-hot pointers, registered head and status flags

module ring_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset_n,

  // Write side, an entry is taken when i_data_val and o_en are both high
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_data_val,
  output logic             o_en,

  // Read side, the head is popped when i_en and o_data_val are both high
  input  logic             i_en,
  output logic [WIDTH-1:0] o_data,
  output logic             o_data_val,

  // Status flags, all registered
  output logic             o_full,
  output logic             o_empty,
  output logic             o_near_empty
);

  // Storage, one location per entry
  logic [WIDTH-1:0] mem [DEPTH];

  // One bit per location, exactly one bit of each vector is set
  logic [DEPTH-1:0] wr_ptr;
  logic [DEPTH-1:0] rd_ptr;

  // Pointers one and two steps ahead of the current ones
  logic [DEPTH-1:0] wr_ptr_nxt;
  logic [DEPTH-1:0] rd_ptr_nxt;
  logic [DEPTH-1:0] rd_ptr_nxt2;

  // Entry that follows the current head in memory
  logic [WIDTH-1:0] mem_next_head;

  logic             do_write;
  logic             do_read;

  // Moves the set bit to the next location, wrapping from the top back to zero
  // The FIFO needs at least two locations for this to make sense
  function automatic logic [DEPTH-1:0] rotate(input logic [DEPTH-1:0] ptr);
    return {ptr[DEPTH-2:0], ptr[DEPTH-1]};
  endfunction

  // ------------------------------
  // Handshake
  // ------------------------------

  // A full FIFO still takes a write when its head leaves in the same cycle
  assign o_en       = ~o_full | i_en;

  // The head register always holds a real entry whenever anything is stored
  assign o_data_val = ~o_empty;

  assign do_write   = i_data_val & o_en;
  assign do_read    = i_en & ~o_empty;

  assign wr_ptr_nxt  = rotate(wr_ptr);
  assign rd_ptr_nxt  = rotate(rd_ptr);
  assign rd_ptr_nxt2 = rotate(rd_ptr_nxt);

  // One-hot mux, the read pointer one step ahead selects a single location
  always_comb begin
    mem_next_head = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (rd_ptr_nxt[i]) begin
        mem_next_head = mem_next_head | mem[i];
      end
    end
  end

  // ------------------------------
  // Memory
  // ------------------------------

  // Every write lands in memory, the head register is only a copy
  // When full and read at once the written location is the one being popped
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (wr_ptr[i]) begin
          mem[i] <= i_data;
        end
      end
    end
  end

  // ------------------------------
  // Head register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (do_read) begin
      if (o_near_empty) begin
        // The popped entry was the only one, so a new entry goes straight to the head
        // Without a write the FIFO empties and the head keeps its stale value
        if (do_write) begin
          o_data <= i_data;
        end
      end else begin
        // At least two entries are stored, the next one is already in memory
        o_data <= mem_next_head;
      end
    end else if (o_empty && do_write) begin
      // First entry into an empty FIFO shows at the head on the next clock
      o_data <= i_data;
    end
  end

  // ------------------------------
  // Pointers and flags
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr       <= DEPTH'(1);
      rd_ptr       <= DEPTH'(1);
      o_full       <= 1'b0;
      o_empty      <= 1'b1;
      o_near_empty <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr_nxt;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr_nxt;
      end

      // The fill level only changes when exactly one side moves
      unique case ({do_write, do_read})
        2'b10: begin
          // Fills up when the advanced write pointer meets the read pointer
          o_full       <= (wr_ptr_nxt == rd_ptr);
          o_empty      <= 1'b0;
          // One entry after the write only if nothing was stored before
          o_near_empty <= o_empty;
        end
        2'b01: begin
          o_full       <= 1'b0;
          // Empties when the advanced read pointer meets the write pointer
          o_empty      <= (rd_ptr_nxt == wr_ptr);
          // Two entries before the pop leave exactly one behind
          o_near_empty <= (rd_ptr_nxt2 == wr_ptr);
        end
        default: begin
          o_full       <= o_full;
          o_empty      <= o_empty;
          o_near_empty <= o_near_empty;
        end
      endcase
    end
  end

endmodule

// File: hw/packer_pkg.sv
// Data, word, count and FIFO entry types plus the packer state enum

`include "packer_config.svh"

package packer_pkg;

  // ------------------------------
  // Payload types
  // ------------------------------

  // One data byte as it arrives from the producer
  typedef logic [7:0] byte_t;

  // Packed output word, first byte of the word in the lowest lane
  // Lanes past the byte count are always zero
  typedef logic [8*`PACK_BYTES_PER_WORD-1:0] word_t;

  // Number of valid bytes in a word minus one
  typedef logic [$clog2(`PACK_BYTES_PER_WORD)-1:0] count_t;

  // ------------------------------
  // FIFO entries
  // ------------------------------

  // Ingress entry is the last flag sitting directly above the byte
  typedef logic [$bits(byte_t):0] in_entry_t;

  // Egress entry from the top down is last flag, count, then the word
  typedef logic [$bits(word_t)+$bits(count_t):0] out_entry_t;

  // ------------------------------
  // Packer FSM
  // ------------------------------

  // COLLECT pops bytes, EMIT offers the finished word to the egress FIFO
  typedef enum logic {
    COLLECT,
    EMIT
  } pack_state_e;

endpackage

// File: hw/packer_config.svh
// Depth and word size macros for the frame byte packer

`ifndef PACKER_CONFIG_SVH
`define PACKER_CONFIG_SVH

// ------------------------------
// FIFO depths
// ------------------------------

// Ingress FIFO holds single bytes with their last flag
// Eight entries let the producer run ahead while a word waits in the packer
`define PACK_IN_DEPTH 8

// Egress FIFO holds packed words until the consumer takes them
`define PACK_OUT_DEPTH 4

// ------------------------------
// Word format
// ------------------------------

// Bytes gathered into one output word, lane 0 carries the first byte
`define PACK_BYTES_PER_WORD 4

`endif
